// File: verilog/vr_defs.svh
`ifndef VR_DEFS_SVH
`define VR_DEFS_SVH

// Width of one request or reply word
`define VR_DATA_W               64

// Log header memory geometry
`define VR_LOG_DEPTH_W          4
`define VR_LOG_DEPTH            16

// Request type codes, found in the top byte of a request word
`define VR_MSG_SETUP            8'h01
`define VR_MSG_PREPARE          8'h02

// Reply type codes
`define VR_MSG_SETUP_ACK        8'h81
`define VR_MSG_PREPARE_OK       8'h82
`define VR_MSG_PREPARE_NACK     8'h83

`endif

// File: verilog/vr_pkg.sv
`include "vr_defs.svh"

package vr_pkg;

    typedef struct packed {
        logic   [31:0]  src_ip;
        logic   [31:0]  dst_ip;
        logic   [15:0]  src_port;
        logic   [15:0]  dst_port;
    } udp_info;

    typedef struct packed {
        logic   [15:0]  view;
        logic   [15:0]  op_num;
        logic   [15:0]  commit_num;
    } vr_state;

    // Setup request layout, which the replies reuse
    typedef struct packed {
        logic   [7:0]                   msg_type;
        logic   [15:0]                  view;
        logic   [15:0]                  op_num;
        logic   [15:0]                  commit_num;
        logic   [`VR_DATA_W-57:0]       spare;
    } setup_fields;

    typedef struct packed {
        logic   [7:0]                   msg_type;
        logic   [15:0]                  view;
        logic   [15:0]                  op_num;
        logic   [15:0]                  client_id;
        logic   [`VR_DATA_W-57:0]       spare;
    } prep_fields;

    // The type byte sits in the same place in both views
    typedef union packed {
        setup_fields    setup;
        prep_fields     prep;
    } vr_msg_word;

    typedef struct packed {
        logic   [15:0]  view;
        logic   [15:0]  op_num;
        logic   [15:0]  client_id;
    } log_entry_hdr;

    // A reply goes back to where its request came from
    function automatic udp_info swap_addr(input udp_info info);
        udp_info swapped;
        swapped.src_ip   = info.dst_ip;
        swapped.dst_ip   = info.src_ip;
        swapped.src_port = info.dst_port;
        swapped.dst_port = info.src_port;
        return swapped;
    endfunction

endpackage

// File: verilog/req_splitter.sv
`include "vr_defs.svh"

module req_splitter (
     input  logic                   clk
    ,input  logic                   rst

    ,input  logic                   fr_udp_meta_val
    ,input  vr_pkg::udp_info        fr_udp_meta_info
    ,output logic                   fr_udp_meta_rdy

    ,input  logic                   fr_udp_data_val
    ,input  vr_pkg::vr_msg_word     fr_udp_data
    ,output logic                   fr_udp_data_rdy

    ,output logic                   setup_req_val
    ,input  logic                   setup_req_rdy
    ,output logic                   prep_req_val
    ,input  logic                   prep_req_rdy
    ,output vr_pkg::udp_info        req_info
    ,output vr_pkg::vr_msg_word     req_word
);

    logic   info_full;
    logic   word_full;
    logic   req_full;
    logic   is_setup;
    logic   is_prep;
    logic   req_done;

    assign fr_udp_meta_rdy = ~info_full;
    assign fr_udp_data_rdy = ~word_full;
    assign req_full        = info_full & word_full;

    assign is_setup = req_word.setup.msg_type == `VR_MSG_SETUP;
    assign is_prep  = req_word.prep.msg_type == `VR_MSG_PREPARE;

    assign setup_req_val = req_full & is_setup;
    assign prep_req_val  = req_full & is_prep;

    // Unknown types count as done as soon as the pair is complete
    assign req_done = (setup_req_val & setup_req_rdy)
                    | (prep_req_val & prep_req_rdy)
                    | (req_full & ~is_setup & ~is_prep);

    always_ff @(posedge clk) begin
        if (rst) begin
            info_full <= 1'b0;
            word_full <= 1'b0;
        end
        else if (req_done) begin
            info_full <= 1'b0;
            word_full <= 1'b0;
        end
        else begin
            if (fr_udp_meta_val & fr_udp_meta_rdy) begin
                info_full <= 1'b1;
            end
            if (fr_udp_data_val & fr_udp_data_rdy) begin
                word_full <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fr_udp_meta_val & fr_udp_meta_rdy) begin
            req_info <= fr_udp_meta_info;
        end
        if (fr_udp_data_val & fr_udp_data_rdy) begin
            req_word <= fr_udp_data;
        end
    end

endmodule

// File: verilog/setup_eng.sv
`include "vr_defs.svh"

module setup_eng (
     input  logic                   clk
    ,input  logic                   rst

    ,input  logic                   req_val
    ,input  vr_pkg::udp_info        req_info
    ,input  vr_pkg::vr_msg_word     req_word
    ,output logic                   req_rdy

    ,output logic                   state_wr_val
    ,output vr_pkg::vr_state        state_wr_data

    ,output logic                   meta_val
    ,output vr_pkg::udp_info        meta_info
    ,input  logic                   meta_rdy

    ,output logic                   data_val
    ,output vr_pkg::vr_msg_word     data
    ,input  logic                   data_rdy
);
    import vr_pkg::*;

    setup_fields    ack;
    logic           accept;

    // Idle means neither reply is still waiting to leave
    assign req_rdy = ~meta_val & ~data_val;
    assign accept  = req_val & req_rdy;

    always_comb begin
        ack          = req_word.setup;
        ack.msg_type = `VR_MSG_SETUP_ACK;
        ack.spare    = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_wr_val <= 1'b0;
            meta_val     <= 1'b0;
            data_val     <= 1'b0;
        end
        else begin
            state_wr_val <= accept;
            if (accept) begin
                meta_val <= 1'b1;
                data_val <= 1'b1;
            end
            else begin
                if (meta_rdy) begin
                    meta_val <= 1'b0;
                end
                if (data_rdy) begin
                    data_val <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            meta_info  <= swap_addr(req_info);
            data.setup <= ack;
        end
    end

    // The acknowledgement carries exactly the state being loaded
    assign state_wr_data.view       = data.setup.view;
    assign state_wr_data.op_num     = data.setup.op_num;
    assign state_wr_data.commit_num = data.setup.commit_num;

endmodule

// File: verilog/prepare_eng.sv
`include "vr_defs.svh"

module prepare_eng (
     input  logic                           clk
    ,input  logic                           rst

    ,input  logic                           req_val
    ,input  vr_pkg::udp_info                req_info
    ,input  vr_pkg::vr_msg_word             req_word
    ,output logic                           req_rdy

    ,input  vr_pkg::vr_state                state

    ,output logic                           state_wr_val
    ,output vr_pkg::vr_state                state_wr_data

    ,output logic                           log_wr_val
    ,output logic   [`VR_LOG_DEPTH_W-1:0]   log_wr_addr
    ,output vr_pkg::log_entry_hdr           log_wr_data

    ,output logic                           meta_val
    ,output vr_pkg::udp_info                meta_info
    ,input  logic                           meta_rdy

    ,output logic                           data_val
    ,output vr_pkg::vr_msg_word             data
    ,input  logic                           data_rdy
);
    import vr_pkg::*;

    prep_fields     req;
    setup_fields    reply;
    logic           accept;
    logic           in_order;

    assign req_rdy = ~meta_val & ~data_val;
    assign accept  = req_val & req_rdy;
    assign req     = req_word.prep;

    // Same view and the very next operation number
    assign in_order = (req.view == state.view) && (req.op_num == state.op_num + 16'd1);

    always_comb begin
        reply.msg_type   = in_order ? `VR_MSG_PREPARE_OK : `VR_MSG_PREPARE_NACK;
        reply.view       = state.view;
        reply.op_num     = in_order ? req.op_num : state.op_num;
        reply.commit_num = state.commit_num;
        reply.spare      = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_wr_val <= 1'b0;
            log_wr_val   <= 1'b0;
            meta_val     <= 1'b0;
            data_val     <= 1'b0;
        end
        else begin
            state_wr_val <= accept & in_order;
            log_wr_val   <= accept & in_order;
            if (accept) begin
                meta_val <= 1'b1;
                data_val <= 1'b1;
            end
            else begin
                if (meta_rdy) begin
                    meta_val <= 1'b0;
                end
                if (data_rdy) begin
                    data_val <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            meta_info             <= swap_addr(req_info);
            data.setup            <= reply;
            log_wr_addr           <= req.op_num[`VR_LOG_DEPTH_W-1:0];
            log_wr_data.view      <= req.view;
            log_wr_data.op_num    <= req.op_num;
            log_wr_data.client_id <= req.client_id;
        end
    end

    // Only strobed for an accepted prepare, when the reply holds the new state
    assign state_wr_data.view       = data.setup.view;
    assign state_wr_data.op_num     = data.setup.op_num;
    assign state_wr_data.commit_num = data.setup.commit_num;

endmodule

// File: verilog/out_merger.sv
module out_merger (
     input  logic                   clk
    ,input  logic                   rst

    ,input  logic                   setup_meta_val
    ,input  vr_pkg::udp_info        setup_meta_info
    ,output logic                   setup_meta_rdy
    ,input  logic                   setup_data_val
    ,input  vr_pkg::vr_msg_word     setup_data
    ,output logic                   setup_data_rdy

    ,input  logic                   prep_meta_val
    ,input  vr_pkg::udp_info        prep_meta_info
    ,output logic                   prep_meta_rdy
    ,input  logic                   prep_data_val
    ,input  vr_pkg::vr_msg_word     prep_data
    ,output logic                   prep_data_rdy

    ,output logic                   to_udp_meta_val
    ,output vr_pkg::udp_info        to_udp_meta_info
    ,input  logic                   to_udp_meta_rdy
    ,output logic                   to_udp_data_val
    ,output vr_pkg::vr_msg_word     to_udp_data
    ,input  logic                   to_udp_data_rdy
);

    logic   grant_val;
    logic   grant_prep;
    logic   meta_done;
    logic   data_done;
    logic   meta_open;
    logic   data_open;
    logic   meta_hs;
    logic   data_hs;

    // A channel stays open until its half of the granted reply has moved
    assign meta_open = grant_val & ~meta_done;
    assign data_open = grant_val & ~data_done;

    assign to_udp_meta_val  = meta_open & (grant_prep ? prep_meta_val : setup_meta_val);
    assign to_udp_meta_info = grant_prep ? prep_meta_info : setup_meta_info;
    assign to_udp_data_val  = data_open & (grant_prep ? prep_data_val : setup_data_val);
    assign to_udp_data      = grant_prep ? prep_data : setup_data;

    assign setup_meta_rdy = meta_open & ~grant_prep & to_udp_meta_rdy;
    assign prep_meta_rdy  = meta_open & grant_prep & to_udp_meta_rdy;
    assign setup_data_rdy = data_open & ~grant_prep & to_udp_data_rdy;
    assign prep_data_rdy  = data_open & grant_prep & to_udp_data_rdy;

    assign meta_hs = to_udp_meta_val & to_udp_meta_rdy;
    assign data_hs = to_udp_data_val & to_udp_data_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_val  <= 1'b0;
            grant_prep <= 1'b0;
            meta_done  <= 1'b0;
            data_done  <= 1'b0;
        end
        else if (~grant_val) begin
            // Setup wins when both engines are waiting
            if (setup_meta_val | setup_data_val) begin
                grant_val  <= 1'b1;
                grant_prep <= 1'b0;
            end
            else if (prep_meta_val | prep_data_val) begin
                grant_val  <= 1'b1;
                grant_prep <= 1'b1;
            end
        end
        else if ((meta_done | meta_hs) & (data_done | data_hs)) begin
            grant_val <= 1'b0;
            meta_done <= 1'b0;
            data_done <= 1'b0;
        end
        else begin
            if (meta_hs) begin
                meta_done <= 1'b1;
            end
            if (data_hs) begin
                data_done <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/log_hdr_mem.sv
`include "vr_defs.svh"

module log_hdr_mem (
     input  logic                           clk

    ,input  logic                           wr_val
    ,input  logic   [`VR_LOG_DEPTH_W-1:0]   wr_addr
    ,input  vr_pkg::log_entry_hdr           wr_data

    ,input  logic   [`VR_LOG_DEPTH_W-1:0]   rd_addr
    ,output vr_pkg::log_entry_hdr           rd_data
);
    import vr_pkg::*;

    log_entry_hdr   mem [0:`VR_LOG_DEPTH-1];

    always_ff @(posedge clk) begin
        if (wr_val) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

// File: verilog/vr_engine.sv
`include "vr_defs.svh"

module vr_engine (
     input  logic                           clk
    ,input  logic                           rst

    ,input  logic                           fr_udp_meta_val
    ,input  vr_pkg::udp_info                fr_udp_meta_info
    ,output logic                           fr_udp_meta_rdy

    ,input  logic                           fr_udp_data_val
    ,input  vr_pkg::vr_msg_word             fr_udp_data
    ,output logic                           fr_udp_data_rdy

    ,output logic                           to_udp_meta_val
    ,output vr_pkg::udp_info                to_udp_meta_info
    ,input  logic                           to_udp_meta_rdy

    ,output logic                           to_udp_data_val
    ,output vr_pkg::vr_msg_word             to_udp_data
    ,input  logic                           to_udp_data_rdy

    ,input  logic   [`VR_LOG_DEPTH_W-1:0]   log_rd_addr
    ,output vr_pkg::log_entry_hdr           log_rd_data
);
    import vr_pkg::*;

    vr_state                        state_reg;

    logic                           setup_req_val;
    logic                           setup_req_rdy;
    logic                           prep_req_val;
    logic                           prep_req_rdy;
    udp_info                        req_info;
    vr_msg_word                     req_word;

    logic                           setup_state_wr_val;
    vr_state                        setup_state_wr_data;
    logic                           prep_state_wr_val;
    vr_state                        prep_state_wr_data;

    logic                           log_wr_val;
    logic   [`VR_LOG_DEPTH_W-1:0]   log_wr_addr;
    log_entry_hdr                   log_wr_data;

    logic                           setup_meta_val;
    udp_info                        setup_meta_info;
    logic                           setup_meta_rdy;
    logic                           setup_data_val;
    vr_msg_word                     setup_data;
    logic                           setup_data_rdy;

    logic                           prep_meta_val;
    udp_info                        prep_meta_info;
    logic                           prep_meta_rdy;
    logic                           prep_data_val;
    vr_msg_word                     prep_data;
    logic                           prep_data_rdy;

    // Setup overrides a prepare update landing in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= '0;
        end
        else if (setup_state_wr_val) begin
            state_reg <= setup_state_wr_data;
        end
        else if (prep_state_wr_val) begin
            state_reg <= prep_state_wr_data;
        end
    end

    req_splitter splitter (
         .clk               (clk                )
        ,.rst               (rst                )
        ,.fr_udp_meta_val   (fr_udp_meta_val    )
        ,.fr_udp_meta_info  (fr_udp_meta_info   )
        ,.fr_udp_meta_rdy   (fr_udp_meta_rdy    )
        ,.fr_udp_data_val   (fr_udp_data_val    )
        ,.fr_udp_data       (fr_udp_data        )
        ,.fr_udp_data_rdy   (fr_udp_data_rdy    )
        ,.setup_req_val     (setup_req_val      )
        ,.setup_req_rdy     (setup_req_rdy      )
        ,.prep_req_val      (prep_req_val       )
        ,.prep_req_rdy      (prep_req_rdy       )
        ,.req_info          (req_info           )
        ,.req_word          (req_word           )
    );

    setup_eng setup (
         .clk               (clk                )
        ,.rst               (rst                )
        ,.req_val           (setup_req_val      )
        ,.req_info          (req_info           )
        ,.req_word          (req_word           )
        ,.req_rdy           (setup_req_rdy      )
        ,.state_wr_val      (setup_state_wr_val )
        ,.state_wr_data     (setup_state_wr_data)
        ,.meta_val          (setup_meta_val     )
        ,.meta_info         (setup_meta_info    )
        ,.meta_rdy          (setup_meta_rdy     )
        ,.data_val          (setup_data_val     )
        ,.data              (setup_data         )
        ,.data_rdy          (setup_data_rdy     )
    );

    prepare_eng prep_eng (
         .clk               (clk                )
        ,.rst               (rst                )
        ,.req_val           (prep_req_val       )
        ,.req_info          (req_info           )
        ,.req_word          (req_word           )
        ,.req_rdy           (prep_req_rdy       )
        ,.state             (state_reg          )
        ,.state_wr_val      (prep_state_wr_val  )
        ,.state_wr_data     (prep_state_wr_data )
        ,.log_wr_val        (log_wr_val         )
        ,.log_wr_addr       (log_wr_addr        )
        ,.log_wr_data       (log_wr_data        )
        ,.meta_val          (prep_meta_val      )
        ,.meta_info         (prep_meta_info     )
        ,.meta_rdy          (prep_meta_rdy      )
        ,.data_val          (prep_data_val      )
        ,.data              (prep_data          )
        ,.data_rdy          (prep_data_rdy      )
    );

    out_merger merger (
         .clk               (clk                )
        ,.rst               (rst                )
        ,.setup_meta_val    (setup_meta_val     )
        ,.setup_meta_info   (setup_meta_info    )
        ,.setup_meta_rdy    (setup_meta_rdy     )
        ,.setup_data_val    (setup_data_val     )
        ,.setup_data        (setup_data         )
        ,.setup_data_rdy    (setup_data_rdy     )
        ,.prep_meta_val     (prep_meta_val      )
        ,.prep_meta_info    (prep_meta_info     )
        ,.prep_meta_rdy     (prep_meta_rdy      )
        ,.prep_data_val     (prep_data_val      )
        ,.prep_data         (prep_data          )
        ,.prep_data_rdy     (prep_data_rdy      )
        ,.to_udp_meta_val   (to_udp_meta_val    )
        ,.to_udp_meta_info  (to_udp_meta_info   )
        ,.to_udp_meta_rdy   (to_udp_meta_rdy    )
        ,.to_udp_data_val   (to_udp_data_val    )
        ,.to_udp_data       (to_udp_data        )
        ,.to_udp_data_rdy   (to_udp_data_rdy    )
    );

    log_hdr_mem log_hdrs (
         .clk               (clk                )
        ,.wr_val            (log_wr_val         )
        ,.wr_addr           (log_wr_addr        )
        ,.wr_data           (log_wr_data        )
        ,.rd_addr           (log_rd_addr        )
        ,.rd_data           (log_rd_data        )
    );

endmodule

// File: dv/tb_clock.sv
module tb_clock (
     output logic   clk
);
    timeunit 1ns;
    timeprecision 1ps;

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

endmodule

// File: dv/tb_vr_engine.sv
`include "vr_defs.svh"

module tb_vr_engine;
    timeunit 1ns;
    timeprecision 1ps;
    import vr_pkg::*;

    // Eleven directed requests plus the random ones
    localparam int RANDOM_REQS = 24;
    localparam int REQ_COUNT   = 11 + RANDOM_REQS;

    logic                           clk;
    logic                           rst;
    logic                           fr_udp_meta_val;
    udp_info                        fr_udp_meta_info;
    logic                           fr_udp_meta_rdy;
    logic                           fr_udp_data_val;
    vr_msg_word                     fr_udp_data;
    logic                           fr_udp_data_rdy;
    logic                           to_udp_meta_val;
    udp_info                        to_udp_meta_info;
    logic                           to_udp_meta_rdy;
    logic                           to_udp_data_val;
    vr_msg_word                     to_udp_data;
    logic                           to_udp_data_rdy;
    logic   [`VR_LOG_DEPTH_W-1:0]   log_rd_addr;
    log_entry_hdr                   log_rd_data;

    integer                         seed;
    logic   [31:0]                  rnd_bits;
    logic   [31:0]                  pick;
    udp_info                        rand_info;
    logic                           bp_on;
    int                             mismatches;
    int                             protocol_errors;
    int                             other_errors;

    // Reference model of the replica
    vr_state                        model;
    log_entry_hdr                   model_log [0:`VR_LOG_DEPTH-1];
    logic   [`VR_LOG_DEPTH-1:0]     model_written;
    udp_info                        exp_info_q [$];
    vr_msg_word                     exp_word_q [$];
    udp_info                        exp_info;
    vr_msg_word                     exp_word;

    tb_clock clock_gen (
         .clk   (clk)
    );

    vr_engine dut (
         .clk               (clk                )
        ,.rst               (rst                )
        ,.fr_udp_meta_val   (fr_udp_meta_val    )
        ,.fr_udp_meta_info  (fr_udp_meta_info   )
        ,.fr_udp_meta_rdy   (fr_udp_meta_rdy    )
        ,.fr_udp_data_val   (fr_udp_data_val    )
        ,.fr_udp_data       (fr_udp_data        )
        ,.fr_udp_data_rdy   (fr_udp_data_rdy    )
        ,.to_udp_meta_val   (to_udp_meta_val    )
        ,.to_udp_meta_info  (to_udp_meta_info   )
        ,.to_udp_meta_rdy   (to_udp_meta_rdy    )
        ,.to_udp_data_val   (to_udp_data_val    )
        ,.to_udp_data       (to_udp_data        )
        ,.to_udp_data_rdy   (to_udp_data_rdy    )
        ,.log_rd_addr       (log_rd_addr        )
        ,.log_rd_data       (log_rd_data        )
    );

    function automatic udp_info reverse_route(input udp_info info);
        return {info.dst_ip, info.src_ip, info.dst_port, info.src_port};
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (expected == actual)
        else begin
            mismatches++;
            $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expected, actual);
        end
    endtask

    // Presents one record and one word, each channel finishing on its own
    task automatic send_pair(input udp_info info, input vr_msg_word word);
        logic meta_moved;
        logic data_moved;
        logic meta_hs;
        logic data_hs;
        @(posedge clk);
        fr_udp_meta_val  <= 1'b1;
        fr_udp_meta_info <= info;
        fr_udp_data_val  <= 1'b1;
        fr_udp_data      <= word;
        meta_moved = 1'b0;
        data_moved = 1'b0;
        while (!(meta_moved && data_moved)) begin
            @(negedge clk);
            meta_hs = fr_udp_meta_val && fr_udp_meta_rdy;
            data_hs = fr_udp_data_val && fr_udp_data_rdy;
            @(posedge clk);
            if (meta_hs) begin
                fr_udp_meta_val <= 1'b0;
                meta_moved = 1'b1;
            end
            if (data_hs) begin
                fr_udp_data_val <= 1'b0;
                data_moved = 1'b1;
            end
        end
    endtask

    task automatic setup_request(input udp_info info, input logic [15:0] view,
                                 input logic [15:0] op, input logic [15:0] commit);
        vr_msg_word word;
        vr_msg_word reply;
        word.setup.msg_type   = `VR_MSG_SETUP;
        word.setup.view       = view;
        word.setup.op_num     = op;
        word.setup.commit_num = commit;
        word.setup.spare      = 8'h5a;
        reply                 = word;
        reply.setup.msg_type  = `VR_MSG_SETUP_ACK;
        reply.setup.spare     = 8'h00;
        model.view       = view;
        model.op_num     = op;
        model.commit_num = commit;
        exp_info_q.push_back(reverse_route(info));
        exp_word_q.push_back(reply);
        send_pair(info, word);
    endtask

    task automatic prepare_request(input udp_info info, input logic [15:0] view,
                                   input logic [15:0] op, input logic [15:0] client);
        vr_msg_word                     word;
        vr_msg_word                     reply;
        logic   [`VR_LOG_DEPTH_W-1:0]   idx;
        word.prep.msg_type  = `VR_MSG_PREPARE;
        word.prep.view      = view;
        word.prep.op_num    = op;
        word.prep.client_id = client;
        word.prep.spare     = 8'h00;
        idx = op[`VR_LOG_DEPTH_W-1:0];
        if (view == model.view && op == model.op_num + 16'd1) begin
            reply.setup.msg_type    = `VR_MSG_PREPARE_OK;
            model.op_num            = op;
            model_log[idx].view      = view;
            model_log[idx].op_num    = op;
            model_log[idx].client_id = client;
            model_written[idx]       = 1'b1;
        end
        else begin
            reply.setup.msg_type = `VR_MSG_PREPARE_NACK;
        end
        reply.setup.view       = model.view;
        reply.setup.op_num     = model.op_num;
        reply.setup.commit_num = model.commit_num;
        reply.setup.spare      = 8'h00;
        exp_info_q.push_back(reverse_route(info));
        exp_word_q.push_back(reply);
        send_pair(info, word);
    endtask

    // A word of unknown type is dropped, so nothing is expected
    task automatic junk_request(input udp_info info);
        vr_msg_word word;
        word = {8'h7e, 56'h0123_4567_89ab_cd};
        send_pair(info, word);
    endtask

    task automatic wait_drained();
        while (exp_info_q.size() != 0 || exp_word_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic check_log_entry(input logic [`VR_LOG_DEPTH_W-1:0] idx);
        @(posedge clk);
        log_rd_addr <= idx;
        @(posedge clk);
        @(negedge clk);
        check_value("log_rd_data", {80'd0, model_log[idx]}, {80'd0, log_rd_data});
    endtask

    // Replies are matched in order, record and word each on their own channel
    always @(negedge clk) begin
        if (!rst && to_udp_meta_val && to_udp_meta_rdy) begin
            assert (exp_info_q.size() != 0)
            else begin
                other_errors++;
                $display("Unexpected reply record at time %0t with no request behind it", $time);
            end
            if (exp_info_q.size() != 0) begin
                exp_info = exp_info_q.pop_front();
                check_value("to_udp_meta_info", {32'd0, exp_info}, {32'd0, to_udp_meta_info});
            end
        end
        if (!rst && to_udp_data_val && to_udp_data_rdy) begin
            assert (exp_word_q.size() != 0)
            else begin
                other_errors++;
                $display("Unexpected reply word at time %0t with no request behind it", $time);
            end
            if (exp_word_q.size() != 0) begin
                exp_word = exp_word_q.pop_front();
                check_value("to_udp_data", {64'd0, exp_word}, {64'd0, to_udp_data});
            end
        end
    end

    meta_hold: assert property (@(posedge clk) disable iff (rst)
        to_udp_meta_val && !to_udp_meta_rdy |=> to_udp_meta_val && $stable(to_udp_meta_info))
    else begin
        protocol_errors++;
        $display("Reply record dropped or changed while stalled at time %0t", $time);
    end

    data_hold: assert property (@(posedge clk) disable iff (rst)
        to_udp_data_val && !to_udp_data_rdy |=> to_udp_data_val && $stable(to_udp_data))
    else begin
        protocol_errors++;
        $display("Reply word dropped or changed while stalled at time %0t", $time);
    end

    // Output back-pressure, drawn at the falling edge and applied at the next rising edge
    initial begin
        to_udp_meta_rdy <= 1'b1;
        to_udp_data_rdy <= 1'b1;
        forever begin
            @(negedge clk);
            if (bp_on) begin
                rnd_bits = $random(seed);
            end
            else begin
                rnd_bits = 32'h3;
            end
            @(posedge clk);
            to_udp_meta_rdy <= rnd_bits[0];
            to_udp_data_rdy <= rnd_bits[1];
        end
    end

    initial begin
        repeat (REQ_COUNT * 200) @(posedge clk);
        $display("Timeout: replies still missing after %0d cycles", REQ_COUNT * 200);
        $display("Errors: mismatches=%0d protocol=%0d other=%0d",
                 mismatches, protocol_errors, other_errors + 1);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        seed            = 32'h44c1_fc1c;
        bp_on           = 1'b0;
        mismatches      = 0;
        protocol_errors = 0;
        other_errors    = 0;
        model           = '0;
        model_written   = '0;
        rst              <= 1'b1;
        fr_udp_meta_val  <= 1'b0;
        fr_udp_meta_info <= '0;
        fr_udp_data_val  <= 1'b0;
        fr_udp_data      <= '0;
        log_rd_addr      <= '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_value("to_udp_meta_val", 128'd0, {127'd0, to_udp_meta_val});
        check_value("to_udp_data_val", 128'd0, {127'd0, to_udp_data_val});
        check_value("fr_udp_meta_rdy", 128'd1, {127'd0, fr_udp_meta_rdy});
        check_value("fr_udp_data_rdy", 128'd1, {127'd0, fr_udp_data_rdy});
        setup_request({32'h0a00_0001, 32'h0a00_0002, 16'd5000, 16'd6000}, 16'd3, 16'd0, 16'd0);

        for (int i = 1; i <= 5; i++) begin
            prepare_request({32'h0a00_0010 + i, 32'h0a00_0002, 16'd4000 + 16'(i), 16'd6000},
                            16'd3, 16'(i), 16'h0100 + 16'(i));
        end
        wait_drained();
        for (int i = 1; i <= 5; i++) begin
            check_log_entry(i[`VR_LOG_DEPTH_W-1:0]);
        end

        // Rewind the operation number so that rejected prepares hit written entries
        setup_request({32'h0a00_0003, 32'h0a00_0002, 16'd5001, 16'd6000}, 16'd3, 16'd0, 16'd2);
        prepare_request({32'h0a00_0004, 32'h0a00_0002, 16'd5002, 16'd6000},
                        16'd9, 16'd1, 16'hbad1);
        prepare_request({32'h0a00_0005, 32'h0a00_0002, 16'd5003, 16'd6000},
                        16'd3, 16'd3, 16'hbad3);
        wait_drained();
        check_log_entry(4'd1);
        check_log_entry(4'd3);

        junk_request({32'h0a00_0006, 32'h0a00_0002, 16'd5004, 16'd6000});
        prepare_request({32'h0a00_0007, 32'h0a00_0002, 16'd5005, 16'd6000},
                        16'd3, 16'd1, 16'h0777);
        wait_drained();

        bp_on = 1'b1;
        for (int i = 0; i < RANDOM_REQS; i++) begin
            pick      = $random(seed);
            rand_info = {$random(seed), $random(seed), pick[31:16], pick[15:0]};
            case (pick[2:0])
                3'd0: setup_request(rand_info, model.view + 16'd1, {12'd0, pick[7:4]},
                                    model.op_num);
                3'd1: prepare_request(rand_info, model.view, model.op_num + 16'd2, pick[23:8]);
                3'd2: prepare_request(rand_info, model.view + 16'd1, model.op_num + 16'd1,
                                      pick[23:8]);
                3'd3: junk_request(rand_info);
                default: prepare_request(rand_info, model.view, model.op_num + 16'd1,
                                         pick[23:8]);
            endcase
        end
        wait_drained();
        bp_on = 1'b0;
        for (int i = 0; i < `VR_LOG_DEPTH; i++) begin
            if (model_written[i]) begin
                check_log_entry(i[`VR_LOG_DEPTH_W-1:0]);
            end
        end

        repeat (5) @(posedge clk);
        $display("Errors: mismatches=%0d protocol=%0d other=%0d",
                 mismatches, protocol_errors, other_errors);
        if (mismatches + protocol_errors + other_errors == 0) begin
            $display("Done: no errors");
        end
        else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: vr_engine.f
+incdir+verilog
verilog/vr_pkg.sv
verilog/req_splitter.sv
verilog/setup_eng.sv
verilog/prepare_eng.sv
verilog/out_merger.sv
verilog/log_hdr_mem.sv
verilog/vr_engine.sv
dv/tb_clock.sv
dv/tb_vr_engine.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vr_engine
FILELIST  ?= vr_engine.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(wildcard verilog/*.sv verilog/*.svh dv/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
